/* design/mbus_msg_pkg.sv */
`default_nettype none

// **************************************************
// message level view of a frame
// **************************************************
package mbus_msg_pkg;

	typedef logic [7:0]  addr_t;   // prefix in the high nibble
	typedef logic [3:0]  func_t;   // low nibble of addr_t
	typedef logic [3:0]  prefix_t; // high nibble of addr_t
	typedef logic [31:0] data_t;

	typedef struct packed {
		addr_t addr; // sent first
		data_t data;
	} msg_t;

	// what the host sees on its receive port
	typedef struct packed {
		msg_t msg;
		logic broadcast; // frame came in on the broadcast prefix
	} rx_msg_t;

	localparam prefix_t BROADCAST_PREFIX = 4'h0;
	localparam func_t   CHANNEL_CTRL     = 4'h1; // absorbed by the layer

endpackage

`default_nettype wire

/* design/mbus_line_pkg.sv */
`default_nettype none

// **************************************************
// wire level view of a frame
// **************************************************
package mbus_line_pkg;

	localparam int FRAME_BITS = $bits(mbus_msg_pkg::msg_t); // 8 addr + 32 data

	typedef logic [5:0] bit_count_t; // bits taken or sent so far

	typedef enum logic {
		RX_IDLE,  // waiting for the first strobe
		RX_SHIFT  // frame in progress
	} rx_state_t;

	typedef enum logic [1:0] {
		TX_IDLE, // idle gap, then pick a slot
		TX_LOAD, // copy slot into the shifter
		TX_SEND  // bits on the line
	} tx_state_t;

endpackage

`default_nettype wire

/* design/mbus_rx_deser.sv */
`timescale 1ns/1ps
`default_nettype none

module mbus_rx_deser #(
	parameter int IDLE_LIMIT = 32
) (
	input  wire                CLK_EXT,
	input  wire                RESETn_local,
	input  wire                clkin,
	input  wire                din,
	output mbus_msg_pkg::msg_t frame,
	output logic               frame_valid
);

	localparam int IDLE_W = $clog2(IDLE_LIMIT + 1);
	localparam mbus_line_pkg::bit_count_t LAST_BIT =
		mbus_line_pkg::bit_count_t'(mbus_line_pkg::FRAME_BITS - 1);

	mbus_line_pkg::rx_state_t             state;
	mbus_line_pkg::bit_count_t            bit_cnt;
	logic [IDLE_W-1:0]                    idle_cnt;
	logic [mbus_line_pkg::FRAME_BITS-1:0] shift_q;
	logic                                 clkin_q;
	logic                                 strobe_edge;

	assign strobe_edge = clkin & ~clkin_q; // strobe high now, low last cycle
	assign frame       = mbus_msg_pkg::msg_t'(shift_q);

	// **************************************************
	// strobe sampling and data shifter
	// **************************************************
	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
			clkin_q <= 1'b1; // line must be seen low before the first bit
		else
			clkin_q <= clkin;
	end

	always_ff @(posedge CLK_EXT)
	begin
		if (strobe_edge)
			shift_q <= {shift_q[mbus_line_pkg::FRAME_BITS-2:0], din}; // msb first
	end

	// **************************************************
	// bit counter and idle timeout
	// **************************************************
	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			state       <= mbus_line_pkg::RX_IDLE;
			bit_cnt     <= '0;
			idle_cnt    <= '0;
			frame_valid <= 1'b0;
		end
		else
		begin
			frame_valid <= 1'b0;
			case (state)
				mbus_line_pkg::RX_IDLE:
				begin
					idle_cnt <= '0;
					if (strobe_edge)
					begin
						bit_cnt <= mbus_line_pkg::bit_count_t'(1); // first bit taken
						state   <= mbus_line_pkg::RX_SHIFT;
					end
				end
				mbus_line_pkg::RX_SHIFT:
				begin
					if (strobe_edge)
					begin
						idle_cnt <= '0;
						if (bit_cnt == LAST_BIT)
						begin
							frame_valid <= 1'b1; // shifter holds the full frame now
							bit_cnt     <= '0;
							state       <= mbus_line_pkg::RX_IDLE;
						end
						else
							bit_cnt <= bit_cnt + 1'b1;
					end
					else if (idle_cnt == IDLE_W'(IDLE_LIMIT - 1))
					begin
						bit_cnt <= '0; // drop the partial frame
						state   <= mbus_line_pkg::RX_IDLE;
					end
					else
						idle_cnt <= idle_cnt + 1'b1;
				end
				default:
					state <= mbus_line_pkg::RX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/mbus_layer_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module mbus_layer_ctrl #(
	parameter mbus_msg_pkg::prefix_t LAYER_PREFIX = 4'h3
) (
	input  wire                     CLK_EXT,
	input  wire                     RESETn_local,
	input  wire mbus_msg_pkg::msg_t frame,
	input  wire                     frame_valid,
	output mbus_msg_pkg::rx_msg_t   rx_msg,
	output logic                    rx_req,
	input  wire                     rx_ack,
	output logic                    rx_fail,
	input  wire mbus_msg_pkg::msg_t tx_msg,
	input  wire                     tx_req,
	output logic                    tx_ack,
	output logic                    tx_succ,
	output mbus_msg_pkg::msg_t      fwd_msg,
	output logic                    fwd_valid,
	output mbus_msg_pkg::msg_t      host_msg,
	output logic                    host_valid,
	input  wire                     host_ready,
	input  wire                     tx_done
);

	mbus_msg_pkg::prefix_t frame_prefix;
	mbus_msg_pkg::func_t   frame_func;
	logic                  is_own;
	logic                  is_bcast;
	logic                  is_ctrl;
	logic                  to_host;
	logic                  to_fwd;
	logic                  rx_take;
	logic                  tx_take;
	logic                  tx_pend;

	// **************************************************
	// address decode
	// **************************************************
	assign frame_prefix = frame.addr[7:4];
	assign frame_func   = frame.addr[3:0];
	assign is_own       = (frame_prefix == LAYER_PREFIX);
	assign is_bcast     = (frame_prefix == mbus_msg_pkg::BROADCAST_PREFIX);
	assign is_ctrl      = is_bcast & (frame_func == mbus_msg_pkg::CHANNEL_CTRL);
	assign to_host      = is_own | (is_bcast & ~is_ctrl); // ctrl broadcast acked here
	assign to_fwd       = ~is_own; // broadcasts and foreign prefixes move on

	assign rx_take = frame_valid & to_host & ~rx_req; // buffer free
	assign tx_take = tx_req & host_ready & ~tx_pend;  // one host frame in flight

	// **************************************************
	// host receive buffer
	// **************************************************
	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			rx_req  <= 1'b0;
			rx_fail <= 1'b0;
		end
		else
		begin
			rx_fail <= frame_valid & to_host & rx_req; // host still busy
			if (rx_take)
				rx_req <= 1'b1;
			else if (rx_req && rx_ack)
				rx_req <= 1'b0;
		end
	end

	always_ff @(posedge CLK_EXT)
	begin
		if (rx_take)
		begin
			rx_msg.msg       <= frame;
			rx_msg.broadcast <= is_bcast;
		end
	end

	// **************************************************
	// forward path and host transmit
	// **************************************************
	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			fwd_valid  <= 1'b0;
			host_valid <= 1'b0;
			tx_ack     <= 1'b0;
			tx_pend    <= 1'b0;
			tx_succ    <= 1'b0;
		end
		else
		begin
			fwd_valid  <= frame_valid & to_fwd;
			host_valid <= tx_take;
			tx_ack     <= tx_take;
			tx_succ    <= tx_done & tx_pend; // last bit of our own frame is out
			if (tx_take)
				tx_pend <= 1'b1;
			else if (tx_done)
				tx_pend <= 1'b0;
		end
	end

	always_ff @(posedge CLK_EXT)
	begin
		if (frame_valid)
			fwd_msg <= frame; // passed on unchanged
		if (tx_take)
			host_msg <= tx_msg;
	end

endmodule

`default_nettype wire

/* design/mbus_tx_ser.sv */
`timescale 1ns/1ps
`default_nettype none

module mbus_tx_ser #(
	parameter int BIT_PERIOD = 4
) (
	input  wire                     CLK_EXT,
	input  wire                     RESETn_local,
	input  wire mbus_msg_pkg::msg_t fwd_msg,
	input  wire                     fwd_valid,
	input  wire mbus_msg_pkg::msg_t host_msg,
	input  wire                     host_valid,
	output logic                    host_ready,
	output logic                    tx_done,
	output logic                    clkout,
	output logic                    dout
);

	localparam int TIMER_W    = $clog2(BIT_PERIOD + 1);
	localparam int GAP_CYCLES = 2 * BIT_PERIOD; // two idle bits between frames
	localparam int GAP_W      = $clog2(GAP_CYCLES + 1);
	localparam mbus_line_pkg::bit_count_t LAST_BIT =
		mbus_line_pkg::bit_count_t'(mbus_line_pkg::FRAME_BITS - 1);

	mbus_line_pkg::tx_state_t             state;
	mbus_msg_pkg::msg_t                   fwd_buf;
	mbus_msg_pkg::msg_t                   host_buf;
	logic                                 fwd_full;
	logic                                 host_full;
	logic [mbus_line_pkg::FRAME_BITS-1:0] shift_q;
	mbus_line_pkg::bit_count_t            bit_cnt;
	logic [TIMER_W-1:0]                   timer;
	logic [GAP_W-1:0]                     gap_cnt;
	logic                                 send_host;
	logic                                 sending;
	logic                                 bit_end;
	logic                                 frame_end;
	logic                                 gap_done;

	assign sending    = (state == mbus_line_pkg::TX_SEND);
	assign bit_end    = sending && (timer == TIMER_W'(BIT_PERIOD - 1));
	assign frame_end  = bit_end && (bit_cnt == LAST_BIT);
	assign gap_done   = (gap_cnt == GAP_W'(GAP_CYCLES));
	assign host_ready = ~host_full;
	assign clkout     = bit_end; // strobe in the last cycle of each bit
	assign dout       = sending & shift_q[mbus_line_pkg::FRAME_BITS-1];

	// **************************************************
	// forward and host slots
	// **************************************************
	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			fwd_full  <= 1'b0;
			host_full <= 1'b0;
		end
		else
		begin
			if (state == mbus_line_pkg::TX_LOAD)
			begin
				if (fwd_full)
					fwd_full <= 1'b0; // forward traffic goes first
				else
					host_full <= 1'b0;
			end
			if (fwd_valid)
				fwd_full <= 1'b1;
			if (host_valid)
				host_full <= 1'b1;
		end
	end

	always_ff @(posedge CLK_EXT)
	begin
		if (fwd_valid)
			fwd_buf <= fwd_msg;
		if (host_valid)
			host_buf <= host_msg;
		if (state == mbus_line_pkg::TX_LOAD)
			shift_q <= fwd_full ? fwd_buf : host_buf;
		else if (bit_end)
			shift_q <= {shift_q[mbus_line_pkg::FRAME_BITS-2:0], 1'b0};
	end

	// **************************************************
	// frame sequencer
	// **************************************************
	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			state     <= mbus_line_pkg::TX_IDLE;
			bit_cnt   <= '0;
			timer     <= '0;
			gap_cnt   <= '0;
			send_host <= 1'b0;
			tx_done   <= 1'b0;
		end
		else
		begin
			tx_done <= 1'b0;
			case (state)
				mbus_line_pkg::TX_IDLE:
				begin
					if (!gap_done)
						gap_cnt <= gap_cnt + 1'b1;
					else if (fwd_full || host_full)
						state <= mbus_line_pkg::TX_LOAD;
				end
				mbus_line_pkg::TX_LOAD:
				begin
					send_host <= ~fwd_full; // same choice as the slot logic
					bit_cnt   <= '0;
					timer     <= '0;
					state     <= mbus_line_pkg::TX_SEND;
				end
				mbus_line_pkg::TX_SEND:
				begin
					if (bit_end)
					begin
						timer <= '0;
						if (frame_end)
						begin
							tx_done <= send_host;
							gap_cnt <= '0;
							state   <= mbus_line_pkg::TX_IDLE;
						end
						else
							bit_cnt <= bit_cnt + 1'b1;
					end
					else
						timer <= timer + 1'b1;
				end
				default:
					state <= mbus_line_pkg::TX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/mbus_layer.sv */
`timescale 1ns/1ps
`default_nettype none

module mbus_layer #(
	parameter mbus_msg_pkg::prefix_t LAYER_PREFIX = 4'h3,
	parameter int                    BIT_PERIOD   = 4,  // cycles per outbound bit
	parameter int                    IDLE_LIMIT   = 32  // cycles before a partial frame is dropped
) (
	input  wire                        CLK_EXT,
	input  wire                        RESETn_local,
	input  wire                        clkin,
	input  wire                        din,
	output wire                        clkout,
	output wire                        dout,
	output wire mbus_msg_pkg::rx_msg_t rx_msg,
	output wire                        rx_req,
	input  wire                        rx_ack,
	output wire                        rx_fail,
	input  wire mbus_msg_pkg::msg_t    tx_msg,
	input  wire                        tx_req,
	output wire                        tx_ack,
	output wire                        tx_succ
);

	mbus_msg_pkg::msg_t frame;
	logic               frame_valid;
	mbus_msg_pkg::msg_t fwd_msg;
	logic               fwd_valid;
	mbus_msg_pkg::msg_t host_msg;
	logic               host_valid;
	logic               host_ready;
	logic               tx_done;

	// **************************************************
	// input side, decode, output side
	// **************************************************
	mbus_rx_deser #(
		.IDLE_LIMIT(IDLE_LIMIT)
	) rx0 (
		.CLK_EXT(CLK_EXT),
		.RESETn_local(RESETn_local),
		.clkin(clkin),
		.din(din),
		.frame(frame),
		.frame_valid(frame_valid)
	);

	mbus_layer_ctrl #(
		.LAYER_PREFIX(LAYER_PREFIX)
	) ctrl0 (
		.CLK_EXT(CLK_EXT),
		.RESETn_local(RESETn_local),
		.frame(frame),
		.frame_valid(frame_valid),
		.rx_msg(rx_msg),
		.rx_req(rx_req),
		.rx_ack(rx_ack),
		.rx_fail(rx_fail),
		.tx_msg(tx_msg),
		.tx_req(tx_req),
		.tx_ack(tx_ack),
		.tx_succ(tx_succ),
		.fwd_msg(fwd_msg),
		.fwd_valid(fwd_valid),
		.host_msg(host_msg),
		.host_valid(host_valid),
		.host_ready(host_ready),
		.tx_done(tx_done)
	);

	mbus_tx_ser #(
		.BIT_PERIOD(BIT_PERIOD)
	) tx0 (
		.CLK_EXT(CLK_EXT),
		.RESETn_local(RESETn_local),
		.fwd_msg(fwd_msg),
		.fwd_valid(fwd_valid),
		.host_msg(host_msg),
		.host_valid(host_valid),
		.host_ready(host_ready),
		.tx_done(tx_done),
		.clkout(clkout),
		.dout(dout)
	);

endmodule

`default_nettype wire

/* verif/mbus_layer_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mbus_layer_checker (
	input wire CLK_EXT,
	input wire RESETn_local,
	input wire rx_req,
	input wire rx_ack,
	input wire rx_fail,
	input wire tx_ack,
	input wire clkout
);

	// **************************************************
	// host handshakes
	// **************************************************
	property rx_req_holds;
		@(posedge CLK_EXT) disable iff (!RESETn_local)
			(rx_req && !rx_ack) |=> rx_req;
	endproperty

	property tx_ack_single;
		@(posedge CLK_EXT) disable iff (!RESETn_local)
			tx_ack |=> !tx_ack;
	endproperty

	property req_fail_apart;
		@(posedge CLK_EXT) disable iff (!RESETn_local)
			!(rx_req && rx_fail);
	endproperty

	// **************************************************
	// outbound strobe
	// **************************************************
	property clkout_single;
		@(posedge CLK_EXT) disable iff (!RESETn_local)
			clkout |=> !clkout;
	endproperty

	rx_req_hold_a: assert property (rx_req_holds)
		else $error("rx_req dropped before rx_ack was seen");
	tx_ack_pulse_a: assert property (tx_ack_single)
		else $error("tx_ack high for more than one cycle");
	req_fail_a: assert property (req_fail_apart)
		else $error("rx_req and rx_fail high together");
	clkout_pulse_a: assert property (clkout_single)
		else $error("clkout high for two cycles in a row");

endmodule

bind mbus_layer mbus_layer_checker chk0 (
	.CLK_EXT(CLK_EXT),
	.RESETn_local(RESETn_local),
	.rx_req(rx_req),
	.rx_ack(rx_ack),
	.rx_fail(rx_fail),
	.tx_ack(tx_ack),
	.clkout(clkout)
);

`default_nettype wire

/* verif/mbus_layer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mbus_layer_tb;

	localparam int CLK_PERIOD   = 40;
	localparam int DRIVE_DELAY  = 5;    // inputs move this long after the rising edge
	localparam int RESET_CYCLES = 16;
	localparam int BIT_PERIOD   = 4;
	localparam int IDLE_LIMIT   = 32;
	localparam int MAX_CASES    = 32;
	localparam int WAIT_LIMIT   = 1000; // cycles per wait loop
	localparam int QUIET_CYCLES = 200;  // longer than one outbound frame
	localparam int FRAME_BITS   = mbus_line_pkg::FRAME_BITS;
	localparam mbus_msg_pkg::prefix_t LAYER_PREFIX = 4'h3;

	localparam logic [3:0] KIND_HOST       = 4'h1;
	localparam logic [3:0] KIND_STRAY      = 4'h2;
	localparam logic [3:0] KIND_END        = 4'hf;
	localparam logic [3:0] OUT_DELIVER     = 4'h1;
	localparam logic [3:0] OUT_DELIVER_FWD = 4'h2;

	localparam int CNT_RX   = 0;
	localparam int CNT_OUT  = 1;
	localparam int CNT_ACK  = 2;
	localparam int CNT_SUCC = 3;

	logic                       CLK_EXT;
	logic                       RESETn_local;
	logic                       clkin;
	logic                       din;
	wire                        clkout;
	wire                        dout;
	wire mbus_msg_pkg::rx_msg_t rx_msg;
	wire                        rx_req;
	logic                       rx_ack;
	wire                        rx_fail;
	mbus_msg_pkg::msg_t         tx_msg;
	logic                       tx_req;
	wire                        tx_ack;
	wire                        tx_succ;

	logic [31:0]               vec_mem [0:4*MAX_CASES-1]; // kind, addr, data, outcome
	mbus_msg_pkg::msg_t        out_q[$];                  // frames seen on clkout/dout
	mbus_msg_pkg::rx_msg_t     rx_q[$];                   // frames taken by the host model
	logic [FRAME_BITS-1:0]     out_shift;
	int                        out_bits;
	int                        tx_ack_cnt;
	int                        tx_succ_cnt;
	int                        rx_fail_cnt;
	logic [31:0]               lfsr;

	mbus_layer #(
		.LAYER_PREFIX(LAYER_PREFIX),
		.BIT_PERIOD(BIT_PERIOD),
		.IDLE_LIMIT(IDLE_LIMIT)
	) dut0 (
		.CLK_EXT(CLK_EXT),
		.RESETn_local(RESETn_local),
		.clkin(clkin),
		.din(din),
		.clkout(clkout),
		.dout(dout),
		.rx_msg(rx_msg),
		.rx_req(rx_req),
		.rx_ack(rx_ack),
		.rx_fail(rx_fail),
		.tx_msg(tx_msg),
		.tx_req(tx_req),
		.tx_ack(tx_ack),
		.tx_succ(tx_succ)
	);

	initial
	begin
		CLK_EXT = 1'b0;
		forever #(CLK_PERIOD/2) CLK_EXT = ~CLK_EXT;
	end

	// **************************************************
	// helpers
	// **************************************************
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0]; // taps 32 22 2 1
		return {s[30:0], fb};
	endfunction

	function automatic int event_count(input int which);
		case (which)
			CNT_RX:  return rx_q.size();
			CNT_OUT: return out_q.size();
			CNT_ACK: return tx_ack_cnt;
			default: return tx_succ_cnt;
		endcase
	endfunction

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [39:0] got,
		input logic [39:0] exp);
		assert (got === exp)
		else
			report_error($sformatf("mismatch at %0t ns: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic wait_count(input int which, input int target, input string what);
		int n;
		n = 0;
		while (event_count(which) < target && n < WAIT_LIMIT)
		begin
			@(posedge CLK_EXT);
			n++;
		end
		assert (event_count(which) >= target)
		else
			report_error($sformatf("timeout at %0t ns while waiting for %s", $time, what));
	endtask

	// **************************************************
	// bus driver and host transmit
	// **************************************************
	task automatic send_bus_bits(input logic [FRAME_BITS-1:0] bits, input int count);
		for (int i = 0; i < count; i++)
		begin
			for (int c = 0; c < BIT_PERIOD; c++)
			begin
				@(posedge CLK_EXT);
				#DRIVE_DELAY;
				din   = bits[FRAME_BITS-1-i]; // msb first
				clkin = (c == BIT_PERIOD - 1); // strobe in the last cycle
			end
		end
		@(posedge CLK_EXT);
		#DRIVE_DELAY;
		clkin = 1'b0;
		din   = 1'b0;
	endtask

	task automatic send_host_frame(input mbus_msg_pkg::msg_t m);
		int ack_start;
		ack_start = tx_ack_cnt;
		@(posedge CLK_EXT);
		#DRIVE_DELAY;
		tx_msg = m;
		tx_req = 1'b1;
		wait_count(CNT_ACK, ack_start + 1, "tx_ack");
		#DRIVE_DELAY;
		tx_req = 1'b0;
	endtask

	// **************************************************
	// monitor and host receive model
	// **************************************************
	always @(negedge CLK_EXT)
	begin
		if (!RESETn_local)
		begin
			out_bits    = 0;
			tx_ack_cnt  = 0;
			tx_succ_cnt = 0;
			rx_fail_cnt = 0;
		end
		else
		begin
			if (clkout)
			begin
				out_shift = {out_shift[FRAME_BITS-2:0], dout};
				out_bits++;
				if (out_bits == FRAME_BITS)
				begin
					out_q.push_back(mbus_msg_pkg::msg_t'(out_shift));
					out_bits = 0;
				end
			end
			if (tx_ack)
				tx_ack_cnt++;
			if (tx_succ)
				tx_succ_cnt++;
			if (rx_fail)
				rx_fail_cnt++;
		end
	end

	initial
	begin : host_rx
		logic [1:0] delay;
		rx_ack = 1'b0;
		lfsr   = 32'h5c2;
		forever
		begin
			@(negedge CLK_EXT);
			if (rx_req)
			begin
				for (int i = 0; i < 2; i++)
				begin
					lfsr     = lfsr_step(lfsr); // one step per bit
					delay[i] = lfsr[0];
				end
				rx_q.push_back(rx_msg);
				repeat (delay) @(posedge CLK_EXT);
				@(posedge CLK_EXT);
				#DRIVE_DELAY rx_ack = 1'b1;
				@(posedge CLK_EXT);
				#DRIVE_DELAY rx_ack = 1'b0;
			end
		end
	end

	// **************************************************
	// one test case
	// **************************************************
	task automatic run_case(input logic [3:0] kind, input mbus_msg_pkg::msg_t m,
		input logic [3:0] outcome);
		int                    rx_start;
		int                    out_start;
		int                    ack_start;
		int                    succ_start;
		int                    exp_out;
		int                    exp_rx;
		logic [FRAME_BITS-1:0] junk;
		mbus_msg_pkg::rx_msg_t got_rx;
		rx_start   = rx_q.size();
		out_start  = out_q.size();
		ack_start  = tx_ack_cnt;
		succ_start = tx_succ_cnt;
		exp_rx     = (kind != KIND_HOST && (outcome == OUT_DELIVER ||
			outcome == OUT_DELIVER_FWD)) ? 1 : 0;
		exp_out    = (kind == KIND_HOST || outcome != OUT_DELIVER) ? 1 : 0;
		if (kind == KIND_HOST)
		begin
			send_host_frame(m);
			wait_count(CNT_OUT, out_start + 1, "host frame on clkout");
			wait_count(CNT_SUCC, succ_start + 1, "tx_succ");
		end
		else
		begin
			if (kind == KIND_STRAY)
			begin
				junk = ~m;
				send_bus_bits(junk, 13); // half frame, then silence
				repeat (IDLE_LIMIT + 8) @(posedge CLK_EXT);
			end
			send_bus_bits(m, FRAME_BITS);
			if (exp_rx == 1)
			begin
				wait_count(CNT_RX, rx_start + 1, "rx_req");
				got_rx = rx_q[rx_start];
				check_value("rx_msg.msg", got_rx.msg, m);
				check_value("rx_msg.broadcast", 40'(got_rx.broadcast),
					40'(outcome == OUT_DELIVER_FWD));
			end
			if (exp_out == 1)
				wait_count(CNT_OUT, out_start + 1, "forwarded frame");
		end
		repeat (QUIET_CYCLES) @(posedge CLK_EXT); // late traffic shows up here
		check_value("outbound frame count", 40'(out_q.size() - out_start), 40'(exp_out));
		check_value("rx_req count", 40'(rx_q.size() - rx_start), 40'(exp_rx));
		if (exp_out == 1)
			check_value("clkout/dout frame", out_q[out_start], m);
		check_value("tx_ack count", 40'(tx_ack_cnt - ack_start), 40'(kind == KIND_HOST));
		check_value("tx_succ count", 40'(tx_succ_cnt - succ_start), 40'(kind == KIND_HOST));
	endtask

	initial
	begin : main
		int                 idx;
		logic [3:0]         kind;
		logic [3:0]         outcome;
		mbus_msg_pkg::msg_t m;
		RESETn_local = 1'b0;
		clkin        = 1'b0;
		din          = 1'b0;
		tx_req       = 1'b0;
		tx_msg       = '0;
		$readmemh("verif/mbus_layer_vectors.txt", vec_mem);
		repeat (RESET_CYCLES) @(posedge CLK_EXT);
		#DRIVE_DELAY;
		RESETn_local = 1'b1;
		repeat (4) @(posedge CLK_EXT);
		idx = 0;
		while (idx < MAX_CASES && vec_mem[4*idx][3:0] != KIND_END)
		begin
			kind    = vec_mem[4*idx][3:0];
			m.addr  = vec_mem[4*idx+1][7:0];
			m.data  = vec_mem[4*idx+2];
			outcome = vec_mem[4*idx+3][3:0];
			run_case(kind, m, outcome);
			idx++;
		end
		assert (idx > 0)
		else
			report_error("no test cases were read from the vectors file");
		check_value("rx_fail count", 40'(rx_fail_cnt), 40'(0));
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/mbus_layer_vectors.txt */
// kind addr data outcome
// kind 0 bus frame, 1 host frame, 2 half frame then idle then bus frame, f end of list
// outcome 1 deliver, 2 deliver and forward, 3 forward only, 4 absorbed
0 30 12345678 1
0 3a a5a5f00d 1
0 02 cafe0001 2
0 0f 0badc0de 2
0 00 55aa55aa 2
0 01 00c0ffee 4
0 01 ffffffff 4
0 51 13572468 3
0 f3 80000001 3
0 23 deadbeef 3
1 52 11223344 3
1 01 89abcdef 3
1 3f 00000000 3
2 34 feedface 1
2 3c 0f0f0f0f 1
f 00 00000000 0

/* mbus_layer.f */
design/mbus_msg_pkg.sv
design/mbus_line_pkg.sv
design/mbus_rx_deser.sv
design/mbus_layer_ctrl.sv
design/mbus_tx_ser.sv
design/mbus_layer.sv
verif/mbus_layer_checker.sv
verif/mbus_layer_tb.sv

/* Makefile */
# Verilator build and run for the MBus layer testbench

VERILATOR  ?= verilator
TOP        ?= mbus_layer_tb
FLIST      ?= mbus_layer.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert -Wall
PASS_MSG   ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# pass or fail is decided by the pass message in the simulation output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)
